// File: spi.f
logic/spi_pkg.sv
logic/spi_master.sv
logic/spi_slave_io.sv
logic/spi_slave.sv
logic/spi_mux.sv
logic/spi.sv
sim/spi_sva.sv
sim/spi_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SPI loopback test with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --assert -Wno-fatal -f spi.f --top-module spi_tb &&
  ./obj_dir/Vspi_tb; } > sim.log 2>&1 || echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// File: sim/spi_tb.sv
// Loopback testbench for the SPI block: clock, reset, packet tasks, register model and checks
`timescale 1ns/1ps
module spi_tb;

   localparam int TIMEOUT = 4000;                  // Cycles allowed per wait
   localparam int NBYTES  = 4;                     // Data bytes per SPI burst

   logic                          clk;
   logic                          rst_n;
   logic                          master_mode;
   logic                          access_in;
   logic [spi_pkg::SPI_PW-1:0]    packet_in;
   logic                          wait_in;
   logic                          spi_irq;
   logic                          access_out;
   logic [spi_pkg::SPI_PW-1:0]    packet_out;
   logic                          wait_out;
   logic                          m_sclk;
   logic                          m_mosi;
   logic                          m_ss;
   logic                          s_miso;
   logic [spi_pkg::SPI_REG_W-1:0] model [spi_pkg::SPI_UREGS]; // Expected slave registers
   integer                        seed;
   integer                        errors;
   integer                        timeouts;
   integer                        irq_count;

   // Master pins looped straight back into the slave
   spi u_dut (
      .clk (clk), .rst_n (rst_n), .master_mode (master_mode),
      .access_in (access_in), .packet_in (packet_in), .wait_in (wait_in),
      .m_miso (s_miso), .s_sclk (m_sclk), .s_mosi (m_mosi), .s_ss (m_ss),
      .spi_irq (spi_irq), .access_out (access_out), .packet_out (packet_out),
      .wait_out (wait_out), .m_sclk (m_sclk), .m_mosi (m_mosi), .m_ss (m_ss),
      .s_miso (s_miso)
   );

   always #20 clk = ~clk;                          // 40 ns period

   always @(negedge clk) begin
      if (rst_n && spi_irq)
         irq_count = irq_count + 1;                // One count per pulse cycle
   end

   //####################################################################
   //# Packet helpers
   //####################################################################

   function automatic logic [spi_pkg::SPI_PW-1:0] make_pkt(input logic wr,
      input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src);
      logic [spi_pkg::SPI_PW-1:0] p;
      p = '0;
      p[spi_pkg::PKT_WRITE_BIT] = wr;
      p[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW]  = dst;
      p[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_AW] = data;
      p[spi_pkg::PKT_SRC_LSB +: spi_pkg::SPI_AW]  = src;
      return p;
   endfunction

   function automatic logic [31:0] slave_addr(input logic [3:0] r);
      return {24'd0, spi_pkg::REGION_SLAVE, 2'b00, r}; // Region in bits 7:6
   endfunction

   task automatic finish_run;
      $display("errors %0d, timeouts %0d, irq pulses %0d", errors, timeouts, irq_count);
      if (errors == 0 && timeouts == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   endtask

   task automatic give_up(input string what);
      timeouts = timeouts + 1;
      $display("timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
      finish_run();
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else begin
         errors = errors + 1;
         $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // All tasks start and end just after a falling edge
   task automatic send(input logic [spi_pkg::SPI_PW-1:0] pkt, input bit forced);
      int n;
      n = 0;
      while (wait_out && !forced) begin            // Core rule: no strobe under wait
         if (n == TIMEOUT)
            give_up("wait_out release");
         n = n + 1;
         @(negedge clk);
      end
      access_in = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic receive(output logic [spi_pkg::SPI_PW-1:0] pkt);
      int n;
      n = 0;
      while (!(access_out && !wait_in)) begin
         if (n == TIMEOUT)
            give_up("packet from the DUT");
         n = n + 1;
         @(negedge clk);
      end
      pkt = packet_out;
      @(negedge clk);                              // Let the transfer edge pass
   endtask

   task automatic wait_pending;
      int n;
      n = 0;
      while (!access_out) begin                    // Held packet, wait_in still high
         if (n == TIMEOUT)
            give_up("held packet");
         n = n + 1;
         @(negedge clk);
      end
   endtask

   task automatic wait_irq(input integer target);
      int n;
      n = 0;
      while (irq_count < target) begin
         if (n == TIMEOUT)
            give_up("spi_irq pulse");
         n = n + 1;
         @(negedge clk);
      end
   endtask

   task automatic master_write(input logic [5:0] off, input logic [31:0] data);
      send(make_pkt(1'b1, {26'd0, off}, data, 32'd0), 1'b0);
   endtask

   // One byte through the master, rx packet checked for its return address
   task automatic spi_byte(input logic [7:0] tx, input logic [31:0] src,
                           output logic [31:0] rx);
      logic [spi_pkg::SPI_PW-1:0] pkt;
      send(make_pkt(1'b1, {26'd0, spi_pkg::MREG_TX}, {24'd0, tx}, src), 1'b0);
      receive(pkt);
      check("rx dstaddr", pkt[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW], src);
      check("rx write bit", {31'd0, pkt[spi_pkg::PKT_WRITE_BIT]}, 32'd1);
      rx = pkt[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_AW];
   endtask

   task automatic core_write(input logic [3:0] r, input logic [7:0] d);
      send(make_pkt(1'b1, slave_addr(r), {24'd0, d}, 32'd0), 1'b0);
      model[r] = d;
   endtask

   task automatic core_read(input logic [3:0] r, input logic [31:0] src);
      logic [spi_pkg::SPI_PW-1:0] pkt;
      send(make_pkt(1'b0, slave_addr(r), 32'd0, src), 1'b0);
      receive(pkt);
      check("read dstaddr", pkt[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW], src);
      check("read data", pkt[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_AW], {24'd0, model[r]});
   endtask

   //####################################################################
   //# Test sequence
   //####################################################################

   initial begin
      logic [spi_pkg::SPI_PW-1:0] pkt;
      logic [31:0]                rx;
      logic [3:0]                 start;
      logic [7:0]                 d;
      integer                     base_irq;
      clk         = 1'b0;
      rst_n       = 1'b1;                          // Edge below fires the async reset
      master_mode = 1'b1;
      access_in   = 1'b0;
      packet_in   = '0;
      wait_in     = 1'b0;
      seed        = 8;
      errors      = 0;
      timeouts    = 0;
      irq_count   = 0;
      #1 rst_n = 1'b0;
      repeat (10) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      // access_out, wait_out, spi_irq, m_ss, m_sclk, s_miso
      check("reset outputs", {26'd0, access_out, wait_out, spi_irq, m_ss, m_sclk, s_miso},
            32'h4);

      // SPI write burst into the slave
      master_write(spi_pkg::MREG_CLKDIV, 32'd4);
      master_write(spi_pkg::MREG_SSHOLD, 32'd1);
      start = 4'($random(seed));
      spi_byte({4'h0, start}, 32'h100, rx);        // Write command
      for (int i = 0; i < NBYTES; i++) begin
         d = 8'($random(seed));
         model[start + 4'(i)] = d;                 // Address auto-increments
         spi_byte(d, 32'h101 + 32'(i), rx);
      end
      base_irq = irq_count;
      master_write(spi_pkg::MREG_SSHOLD, 32'd0);   // ss rises, irq follows
      wait_irq(base_irq + 1);
      for (int i = 0; i < NBYTES; i++)
         core_read(start + 4'(i), 32'h200 + 32'(i));
      check("irq pulses after write", 32'(irq_count), 32'(base_irq + 1));

      // Core fills the slave, SPI reads it back
      for (int r = 0; r < spi_pkg::SPI_UREGS; r++)
         core_write(4'(r), 8'($random(seed)));
      master_write(spi_pkg::MREG_SSHOLD, 32'd1);
      start = 4'($random(seed));
      spi_byte({1'b1, 3'd0, start}, 32'h300, rx); // Read command
      for (int i = 0; i < NBYTES + 1; i++) begin
         spi_byte(8'($random(seed)), 32'h301 + 32'(i), rx);
         check("spi read data", rx, {24'd0, model[start + 4'(i)]});
      end
      master_write(spi_pkg::MREG_SSHOLD, 32'd0);

      // Back-pressure, slave and master packets collide
      wait_in = 1'b1;
      send(make_pkt(1'b1, {26'd0, spi_pkg::MREG_TX}, 32'h80, 32'h400), 1'b0);
      wait_pending();
      send(make_pkt(1'b0, slave_addr(4'd5), 32'd0, 32'h401), 1'b1); // Strobe despite wait
      repeat (3) @(negedge clk);                   // Both held
      wait_in = 1'b0;
      receive(pkt);
      check("first out dstaddr", pkt[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW], 32'h401);
      check("first out data", pkt[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_AW],
            {24'd0, model[5]});
      receive(pkt);
      check("second out dstaddr", pkt[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW], 32'h400);

      // Random dividers, pacing checked by the SVA
      for (int k = 0; k < 4; k++) begin
         master_write(spi_pkg::MREG_CLKDIV, 32'($random(seed)) & 32'hf);
         spi_byte(8'($random(seed)), 32'h500 + 32'(k), rx);
      end

      // TX ignored with master_mode low
      master_mode = 1'b0;
      send(make_pkt(1'b1, {26'd0, spi_pkg::MREG_TX}, 32'h5a, 32'h600), 1'b0);
      repeat (100) begin
         check("idle master ss/access", {30'd0, m_ss, access_out}, 32'd2);
         @(negedge clk);
      end
      master_mode = 1'b1;

      check("irq pulse total", 32'(irq_count), 32'd1);
      finish_run();
   end

endmodule

// File: sim/spi_sva.sv
// Concurrent checks on reset state, return-path hold, sclk pacing and irq timing
`timescale 1ns/1ps
module spi_sva (
   input logic                       clk,
   input logic                       rst_n,
   input logic                       access_in,
   input logic [spi_pkg::SPI_PW-1:0] packet_in,
   input logic                       wait_in,
   input logic                       access_out,
   input logic [spi_pkg::SPI_PW-1:0] packet_out,
   input logic                       wait_out,
   input logic                       spi_irq,
   input logic                       m_sclk,
   input logic                       m_ss,
   input logic                       m_access,   // Master into the mux
   input logic [spi_pkg::SPI_PW-1:0] m_packet,
   input logic                       s_access    // Slave into the mux
);

   logic                             sclk_prev;
   logic [7:0]                       age;        // Cycles since m_sclk last moved
   logic [spi_pkg::SPI_CLKDIV_W-1:0] clkdiv;     // Divider as last written by the core
   logic                             div_wr;

   assign div_wr = access_in & packet_in[spi_pkg::PKT_WRITE_BIT] &
      (packet_in[spi_pkg::PKT_DST_LSB + spi_pkg::SPI_REGION_LSB +: 2] == spi_pkg::REGION_MASTER) &
      (packet_in[spi_pkg::PKT_DST_LSB +: 6] == spi_pkg::MREG_CLKDIV);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sclk_prev <= 1'b0;
         age       <= '1;                       // Saturated, long idle
         clkdiv    <= '0;
      end else begin
         sclk_prev <= m_sclk;
         if (m_sclk != sclk_prev)
            age <= 8'd1;
         else if (age != '1)
            age <= age + 8'd1;
         if (div_wr)
            clkdiv <= packet_in[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_CLKDIV_W];
      end
   end

   reset_state: assert property (@(posedge clk)
      !rst_n |-> !access_out && !wait_out && !spi_irq && m_ss && !m_sclk)
      else $error("outputs not at their reset values");

   // Held output may only be replaced by a higher priority slave packet
   hold_out: assert property (@(posedge clk) disable iff (!rst_n)
      access_out && wait_in |=> access_out && ($stable(packet_out) || $rose(s_access)))
      else $error("return packet changed while wait_in high");

   loser_hold: assert property (@(posedge clk) disable iff (!rst_n)
      m_access && s_access |=> m_access && $stable(m_packet))
      else $error("master packet dropped after losing arbitration");

   sclk_pace: assert property (@(posedge clk) disable iff (!rst_n)
      (m_sclk != sclk_prev) |-> (age > 8'(clkdiv)) && !m_ss)
      else $error("m_sclk moved too early or with m_ss high");

   sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) m_ss |-> !m_sclk)
      else $error("m_sclk high while deselected");

   // Interrupt only once the slave is deselected
   irq_after_ss: assert property (@(posedge clk) disable iff (!rst_n) spi_irq |-> m_ss)
      else $error("spi_irq while m_ss low");

endmodule

bind spi spi_sva u_sva (
   .clk        (clk),
   .rst_n      (rst_n),
   .access_in  (access_in),
   .packet_in  (packet_in),
   .wait_in    (wait_in),
   .access_out (access_out),
   .packet_out (packet_out),
   .wait_out   (wait_out),
   .spi_irq    (spi_irq),
   .m_sclk     (m_sclk),
   .m_ss       (m_ss),
   .m_access   (m_access),
   .m_packet   (m_packet),
   .s_access   (s_access)
);

// File: logic/spi.sv
// SPI top: master, slave and packet mux with merged wait
`timescale 1ns/1ps
module spi (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       master_mode,
   input  logic                       access_in,
   input  logic [spi_pkg::SPI_PW-1:0] packet_in,
   input  logic                       wait_in,
   input  logic                       m_miso,
   input  logic                       s_sclk,
   input  logic                       s_mosi,
   input  logic                       s_ss,
   output logic                       spi_irq,
   output logic                       access_out,
   output logic [spi_pkg::SPI_PW-1:0] packet_out,
   output logic                       wait_out,
   output logic                       m_sclk,
   output logic                       m_mosi,
   output logic                       m_ss,
   output logic                       s_miso
);

   logic                       m_access;
   logic [spi_pkg::SPI_PW-1:0] m_packet;
   logic                       m_wait;   // Mux to master
   logic                       m_busy;   // Master transfer in flight
   logic                       s_access;
   logic [spi_pkg::SPI_PW-1:0] s_packet;
   logic                       s_wait;   // Mux to slave
   logic                       s_pend;   // Slave response pending

   //####################################################################
   //# Master and slave
   //####################################################################

   spi_master spi_master (
      .clk         (clk),
      .rst_n       (rst_n),
      .master_mode (master_mode),
      .access_in   (access_in),
      .packet_in   (packet_in),
      .miso        (m_miso),
      .wait_in     (m_wait),
      .sclk        (m_sclk),
      .mosi        (m_mosi),
      .ss          (m_ss),
      .wait_out    (m_busy),
      .access_out  (m_access),
      .packet_out  (m_packet)
   );

   spi_slave spi_slave (
      .clk        (clk),
      .rst_n      (rst_n),
      .sclk       (s_sclk),
      .mosi       (s_mosi),
      .ss         (s_ss),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (s_wait),
      .miso       (s_miso),
      .spi_irq    (spi_irq),
      .access_out (s_access),
      .packet_out (s_packet),
      .wait_out   (s_pend)
   );

   //####################################################################
   //# Return path
   //####################################################################

   spi_mux spi_mux (
      .a_access   (s_access),
      .a_packet   (s_packet),
      .b_access   (m_access),
      .b_packet   (m_packet),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .a_wait     (s_wait),
      .b_wait     (m_wait)
   );

   assign wait_out = m_busy | s_pend; // Core holds off while either is busy

endmodule

// File: logic/spi_mux.sv
// Two-source fixed-priority packet mux with wait return to the losing source
`timescale 1ns/1ps
module spi_mux (
   input  logic                       a_access,   // Slave, high priority
   input  logic [spi_pkg::SPI_PW-1:0] a_packet,
   input  logic                       b_access,   // Master
   input  logic [spi_pkg::SPI_PW-1:0] b_packet,
   input  logic                       wait_in,    // Pushback from core
   output logic                       access_out,
   output logic [spi_pkg::SPI_PW-1:0] packet_out,
   output logic                       a_wait,
   output logic                       b_wait
);

   assign access_out = a_access | b_access;
   assign packet_out = a_access ? a_packet : b_packet;

   // Source a only ever sees core pushback
   assign a_wait = wait_in;
   assign b_wait = wait_in | a_access;           // Lost arbitration, hold

endmodule

// File: logic/spi_slave.sv
// SPI slave: register file, core read and write access, response packet and interrupt pulse
`timescale 1ns/1ps
module spi_slave (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       sclk,
   input  logic                       mosi,
   input  logic                       ss,
   input  logic                       access_in,
   input  logic [spi_pkg::SPI_PW-1:0] packet_in,
   input  logic                       wait_in,
   output logic                       miso,
   output logic                       spi_irq,
   output logic                       access_out,
   output logic [spi_pkg::SPI_PW-1:0] packet_out,
   output logic                       wait_out    // Response pending
);

   logic [spi_pkg::SPI_REG_W-1:0]         regs [spi_pkg::SPI_UREGS];
   logic [1:0]                            region;
   logic [$clog2(spi_pkg::SPI_UREGS)-1:0] core_addr;
   logic                                  core_sel;
   logic                                  core_we;
   logic                                  core_re;
   logic                                  io_wr_en;
   logic [$clog2(spi_pkg::SPI_UREGS)-1:0] io_rd_addr;
   logic [$clog2(spi_pkg::SPI_UREGS)-1:0] io_wr_addr;
   logic [spi_pkg::SPI_REG_W-1:0]         io_wr_data;
   logic                                  xfer_done;
   logic                                  wrote;

   spi_slave_io spi_slave_io (
      .clk       (clk),
      .rst_n     (rst_n),
      .sclk      (sclk),
      .mosi      (mosi),
      .ss        (ss),
      .rd_data   (regs[io_rd_addr]),
      .miso      (miso),
      .wr_en     (io_wr_en),
      .rd_addr   (io_rd_addr),
      .wr_addr   (io_wr_addr),
      .wr_data   (io_wr_data),
      .xfer_done (xfer_done),
      .wrote     (wrote)
   );

   //####################################################################
   //# Core access
   //####################################################################

   assign region    = packet_in[spi_pkg::PKT_DST_LSB + spi_pkg::SPI_REGION_LSB +: 2];
   assign core_addr = packet_in[spi_pkg::PKT_DST_LSB +: $clog2(spi_pkg::SPI_UREGS)];
   assign core_sel  = access_in & (region == spi_pkg::REGION_SLAVE);
   assign core_we   = core_sel & packet_in[spi_pkg::PKT_WRITE_BIT];
   assign core_re   = core_sel & ~packet_in[spi_pkg::PKT_WRITE_BIT];

   always_ff @(posedge clk) begin
      if (core_we)
         regs[core_addr] <= packet_in[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_REG_W];
      if (io_wr_en)
         regs[io_wr_addr] <= io_wr_data;          // Last write, SPI wins a tie
   end

   // Read response, held until the mux lets it through
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         access_out <= 1'b0;
      else if (core_re)
         access_out <= 1'b1;
      else if (!wait_in)
         access_out <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (core_re) begin
         packet_out <= '0;
         packet_out[spi_pkg::PKT_WRITE_BIT] <= 1'b1;
         packet_out[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW] <=
            packet_in[spi_pkg::PKT_SRC_LSB +: spi_pkg::SPI_AW];
         packet_out[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_REG_W] <= regs[core_addr];
      end
   end

   assign wait_out = access_out;

   // Pulse once ss rises on a transaction that wrote
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         spi_irq <= 1'b0;
      else
         spi_irq <= xfer_done & wrote;
   end

endmodule

// File: logic/spi_slave_io.sv
// SPI slave pin path: synchronizers, command-byte parser, shift registers and miso driver
`timescale 1ns/1ps
module spi_slave_io (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  sclk,
   input  logic                                  mosi,
   input  logic                                  ss,
   input  logic [spi_pkg::SPI_REG_W-1:0]         rd_data, // Register at rd_addr
   output logic                                  miso,
   output logic                                  wr_en,
   output logic [$clog2(spi_pkg::SPI_UREGS)-1:0] rd_addr,
   output logic [$clog2(spi_pkg::SPI_UREGS)-1:0] wr_addr,
   output logic [spi_pkg::SPI_REG_W-1:0]         wr_data,
   output logic                                  xfer_done,
   output logic                                  wrote    // Transaction wrote a register
);

   logic [2:0]                            sclk_q;   // [2] is the previous sample
   logic [2:0]                            ss_q;
   logic [1:0]                            mosi_q;
   logic                                  sclk_rise;
   logic                                  sclk_fall;
   logic                                  ss_low;
   logic                                  ss_rise;
   logic                                  ss_fall;
   logic [2:0]                            bit_cnt;
   logic                                  cmd_phase;  // First byte is the command
   logic                                  is_read;
   logic [$clog2(spi_pkg::SPI_UREGS)-1:0] addr;
   logic [spi_pkg::SPI_REG_W-1:0]         rx_sh;
   logic [spi_pkg::SPI_REG_W-1:0]         rx_byte;
   logic [spi_pkg::SPI_REG_W-1:0]         miso_sh;

   //####################################################################
   //# Pin synchronizers
   //####################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sclk_q <= '0;
         ss_q   <= '1;                            // Deselected
         mosi_q <= '0;
      end else begin
         sclk_q <= {sclk_q[1:0], sclk};
         ss_q   <= {ss_q[1:0], ss};
         mosi_q <= {mosi_q[0], mosi};
      end
   end

   assign sclk_rise = sclk_q[1] & ~sclk_q[2];
   assign sclk_fall = ~sclk_q[1] & sclk_q[2];
   assign ss_low    = ~ss_q[1];
   assign ss_rise   = ss_q[1] & ~ss_q[2];
   assign ss_fall   = ~ss_q[1] & ss_q[2];
   assign rx_byte   = {rx_sh[spi_pkg::SPI_REG_W-2:0], mosi_q[1]}; // Byte incl. this bit

   //####################################################################
   //# Command parser
   //####################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt   <= '0;
         cmd_phase <= 1'b1;
         is_read   <= 1'b0;
         addr      <= '0;
         wr_en     <= 1'b0;
         wrote     <= 1'b0;
      end else begin
         wr_en <= 1'b0;                           // One-cycle pulse
         if (ss_fall)
            wrote <= 1'b0;
         if (!ss_low) begin
            bit_cnt   <= '0;
            cmd_phase <= 1'b1;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
               if (cmd_phase) begin
                  cmd_phase <= 1'b0;
                  is_read   <= rx_byte[spi_pkg::SPI_CMD_READ_BIT];
                  addr      <= rx_byte[$clog2(spi_pkg::SPI_UREGS)-1:0];
               end else begin
                  addr <= addr + 1'b1;            // Auto-increment
                  if (!is_read) begin
                     wr_en <= 1'b1;
                     wrote <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // Write payload, captured with the last bit of a byte
   always_ff @(posedge clk) begin
      if (sclk_rise)
         rx_sh <= rx_byte;
      if (sclk_rise & (bit_cnt == 3'd7)) begin
         wr_addr <= addr;
         wr_data <= rx_byte;
      end
   end

   assign rd_addr   = addr;
   assign xfer_done = ss_rise;

   //####################################################################
   //# Miso driver
   //####################################################################

   // Falling edge at a byte boundary loads the next register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         miso_sh <= '0;
      else if (ss_low & sclk_fall) begin
         if (bit_cnt == 3'd0)
            miso_sh <= rd_data;
         else
            miso_sh <= {miso_sh[spi_pkg::SPI_REG_W-2:0], 1'b0};
      end
   end

   assign miso = miso_sh[spi_pkg::SPI_REG_W-1];

endmodule

// File: logic/spi_master.sv
// SPI master: register decode, sclk divider, byte shift engine and received-byte packet
`timescale 1ns/1ps
module spi_master (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          master_mode, // Gates TX starts
   input  logic                          access_in,
   input  logic [spi_pkg::SPI_PW-1:0]    packet_in,
   input  logic                          miso,
   input  logic                          wait_in,     // Pushback on rx packet
   output logic                          sclk,
   output logic                          mosi,
   output logic                          ss,
   output logic                          wait_out,    // Busy until rx packet taken
   output logic                          access_out,
   output logic [spi_pkg::SPI_PW-1:0]    packet_out
);

   logic [1:0]                       region;
   logic [5:0]                       offset;
   logic                             wr_sel;
   logic                             tx_start;
   logic [spi_pkg::SPI_CLKDIV_W-1:0] clkdiv;
   logic                             sshold;
   logic [spi_pkg::SPI_CLKDIV_W-1:0] div_cnt;   // Counts down one half period
   logic [4:0]                       phase;     // Half period 0..16
   logic                             shifting;
   logic                             tick;
   logic                             last_tick;
   logic [spi_pkg::SPI_REG_W-1:0]    tx_sh;
   logic [spi_pkg::SPI_REG_W-1:0]    rx_sh;
   logic [spi_pkg::SPI_AW-1:0]       rsp_addr;  // Srcaddr of the TX request

   //####################################################################
   //# Register decode
   //####################################################################

   assign region = packet_in[spi_pkg::PKT_DST_LSB + spi_pkg::SPI_REGION_LSB +: 2];
   assign offset = packet_in[spi_pkg::PKT_DST_LSB +: 6];
   assign wr_sel = access_in & packet_in[spi_pkg::PKT_WRITE_BIT] &
                   (region == spi_pkg::REGION_MASTER);

   // Ignored entirely when not in master mode
   assign tx_start = wr_sel & master_mode & (offset == spi_pkg::MREG_TX);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         clkdiv <= '0;
         sshold <= 1'b0;
      end else if (wr_sel) begin
         if (offset == spi_pkg::MREG_CLKDIV)
            clkdiv <= packet_in[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_CLKDIV_W];
         if (offset == spi_pkg::MREG_SSHOLD)
            sshold <= packet_in[spi_pkg::PKT_DATA_LSB]; // Keeps ss low between bytes
      end
   end

   //####################################################################
   //# Divider and sclk
   //####################################################################

   assign tick      = shifting & (div_cnt == '0);
   assign last_tick = tick & (phase == 5'd16); // Trailing ss half period done

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shifting <= 1'b0;
         phase    <= '0;
         div_cnt  <= '0;
         sclk     <= 1'b0;
      end else if (tx_start) begin
         shifting <= 1'b1;
         phase    <= '0;
         div_cnt  <= clkdiv;
      end else if (tick) begin
         div_cnt <= clkdiv;
         phase   <= phase + 5'd1;
         if (last_tick)
            shifting <= 1'b0;
         if (!phase[4])
            sclk <= ~sclk;                     // Odd phases high, phase 16 low
      end else if (shifting) begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

   // Slave select, drops the cycle after the TX write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         ss <= 1'b1;
      else if (tx_start)
         ss <= 1'b0;
      else if ((last_tick | ~shifting) & ~sshold)
         ss <= 1'b1;
   end

   //####################################################################
   //# Shift engine
   //####################################################################

   always_ff @(posedge clk) begin
      if (tx_start) begin
         tx_sh    <= packet_in[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_REG_W];
         rsp_addr <= packet_in[spi_pkg::PKT_SRC_LSB +: spi_pkg::SPI_AW];
      end else if (tick & phase[0]) begin
         tx_sh <= {tx_sh[spi_pkg::SPI_REG_W-2:0], 1'b0}; // Falling edge
      end
      if (tick & ~phase[0] & ~phase[4])
         rx_sh <= {rx_sh[spi_pkg::SPI_REG_W-2:0], miso}; // Rising edge sample
   end

   assign mosi = tx_sh[spi_pkg::SPI_REG_W-1]; // MSB first

   //####################################################################
   //# Received-byte packet
   //####################################################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         access_out <= 1'b0;
         wait_out   <= 1'b0;
      end else begin
         if (tx_start)
            wait_out <= 1'b1;
         else if (access_out & ~wait_in)
            wait_out <= 1'b0;
         if (last_tick)
            access_out <= 1'b1;
         else if (!wait_in)
            access_out <= 1'b0;                // Taken by the mux
      end
   end

   always_ff @(posedge clk) begin
      if (last_tick) begin
         packet_out <= '0;
         packet_out[spi_pkg::PKT_WRITE_BIT] <= 1'b1;
         packet_out[spi_pkg::PKT_DST_LSB +: spi_pkg::SPI_AW] <= rsp_addr;
         packet_out[spi_pkg::PKT_DATA_LSB +: spi_pkg::SPI_REG_W] <= rx_sh;
      end
   end

endmodule

// File: logic/spi_pkg.sv
// Bus widths, packet field positions, address map and register counts of the SPI block
package spi_pkg;

   //####################################################################
   //# Bus and packet layout
   //####################################################################

   localparam int SPI_AW = 32;            // Address and data width
   localparam int SPI_PW = 2*SPI_AW + 40; // 104-bit packet

   // Fields from the low end: write, datamode[2], ctrlmode[5], dst, data, src
   localparam int PKT_WRITE_BIT = 0;
   localparam int PKT_DST_LSB   = 8;
   localparam int PKT_DATA_LSB  = PKT_DST_LSB + SPI_AW;
   localparam int PKT_SRC_LSB   = PKT_DATA_LSB + SPI_AW;

   //####################################################################
   //# Address map
   //####################################################################

   localparam int SPI_REGION_LSB = 6;     // Region field sits in dstaddr[7:6]

   localparam logic [1:0] REGION_MASTER = 2'd0;
   localparam logic [1:0] REGION_SLAVE  = 2'd1;

   // Master register offsets, low 6 address bits
   localparam logic [5:0] MREG_CLKDIV = 6'd0;
   localparam logic [5:0] MREG_TX     = 6'd1;
   localparam logic [5:0] MREG_SSHOLD = 6'd2;

   //####################################################################
   //# Slave register file and transfer format
   //####################################################################

   localparam int SPI_UREGS        = 16;  // 8-bit user registers
   localparam int SPI_REG_W        = 8;   // Register and byte width
   localparam int SPI_CMD_READ_BIT = 7;   // Command byte bit, 1 = read

   localparam int SPI_CLKDIV_W = 4;       // Half period = clkdiv+1 clk cycles

endpackage
